// ==== srl_fifo_consts.svh ====
// ------------------------------------------------------------------
// byte FIFO constants
// widths, depth, register map and watermark reset values
// ------------------------------------------------------------------

`ifndef SRL_FIFO_CONSTS_SVH
`define SRL_FIFO_CONSTS_SVH

// data path and storage
`define FIFO_DATA_WIDTH     8
`define FIFO_PTR_WIDTH      4
`define FIFO_DEPTH          16

// register port
`define REG_ADDR_WIDTH      2
`define REG_DATA_WIDTH      8

// register map
`define REG_ADDR_AF_THRESH  2'd0
`define REG_ADDR_AE_THRESH  2'd1
`define REG_ADDR_STATUS     2'd2
`define REG_ADDR_COUNT      2'd3

// watermark defaults
`define AF_THRESH_RESET     8'd14
`define AE_THRESH_RESET     8'd2

`endif

// ==== srl_fifo_pkg.sv ====
// ------------------------------------------------------------------
// byte FIFO package
// shared data, pointer, count and register types
// ------------------------------------------------------------------

`include "srl_fifo_consts.svh"

package srl_fifo_pkg;

    // one stored byte
    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

    // tap select / read pointer
    typedef logic [`FIFO_PTR_WIDTH-1:0] ptr_t;

    // one extra bit so a full count of 16 fits
    typedef logic [`FIFO_PTR_WIDTH:0] count_t;

    // register port
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

endpackage

// ==== srl_shift_register.sv ====
// ------------------------------------------------------------------
// shift register with selectable output tap
// newest word sits at place 0, older words move deeper on each shift
// ------------------------------------------------------------------

`timescale 1ns/1ns

`include "srl_fifo_consts.svh"

module srl_shift_register (
    input  logic                clk,
    input  logic                shift_en,
    input  srl_fifo_pkg::data_t shift_data,
    input  srl_fifo_pkg::ptr_t  tap,
    output srl_fifo_pkg::data_t tap_data
);

    // storage, contents undefined until written
    srl_fifo_pkg::data_t mem [0:`FIFO_DEPTH-1];

    // ------------------------------------------------------------------
    // shift chain
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = `FIFO_DEPTH - 1; i > 0; i--) begin
                mem[i] <= mem[i-1];
            end
            mem[0] <= shift_data;
        end
    end

    // ------------------------------------------------------------------
    // tap select
    // ------------------------------------------------------------------
    // combinational read, maps onto LUT shift registers
    assign tap_data = mem[tap];

endmodule

// ==== srl_fifo.sv ====
// ------------------------------------------------------------------
// byte FIFO control around a tapped shift register
// pointer, empty/full flags, counts, output register, reject pulses
// ------------------------------------------------------------------

`timescale 1ns/1ns

`include "srl_fifo_consts.svh"

module srl_fifo (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 wr_en,
    input  srl_fifo_pkg::data_t  wr_data,

    input  logic                 rd_en,
    output srl_fifo_pkg::data_t  rd_data,

    output logic                 full,
    output logic                 empty,
    output srl_fifo_pkg::count_t data_count,
    output srl_fifo_pkg::count_t free_count,

    output logic                 wr_reject,
    output logic                 rd_reject
);

    // accepted accesses
    logic                 write_en;
    logic                 read_en;

    // pointer to the oldest entry
    srl_fifo_pkg::ptr_t   ptr;
    srl_fifo_pkg::count_t next_ptr;

    // word at the oldest place
    srl_fifo_pkg::data_t  tap_data;

    // while full, a write goes through only with a read beside it
    assign write_en = wr_en & (~full | rd_en);
    assign read_en  = rd_en & ~empty;

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------
    srl_shift_register u_shift_register (
        .clk        (clk),
        .shift_en   (write_en),
        .shift_data (wr_data),
        .tap        (ptr),
        .tap_data   (tap_data)
    );

    // ------------------------------------------------------------------
    // pointer and flags
    // ------------------------------------------------------------------
    // extra top bit catches the step below zero
    assign next_ptr = {1'b0, ptr}
                    + srl_fifo_pkg::count_t'(write_en)
                    - srl_fifo_pkg::count_t'(read_en);

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr   <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else if (empty) begin
            // only a write counts here, any read is dropped
            ptr   <= '0;
            empty <= ~write_en;
            full  <= 1'b0;
        end else begin
            if (next_ptr[`FIFO_PTR_WIDTH]) begin
                ptr <= '0;
            end else begin
                ptr <= next_ptr[`FIFO_PTR_WIDTH-1:0];
            end
            empty <= next_ptr[`FIFO_PTR_WIDTH];
            full  <= (next_ptr == srl_fifo_pkg::count_t'(`FIFO_DEPTH - 1));
        end
    end

    // ------------------------------------------------------------------
    // counts
    // ------------------------------------------------------------------
    assign data_count = {1'b0, ptr} + srl_fifo_pkg::count_t'(!empty);
    assign free_count = srl_fifo_pkg::count_t'(`FIFO_DEPTH) - data_count;

    // ------------------------------------------------------------------
    // output data register
    // ------------------------------------------------------------------
    // holds the popped word until the next accepted read
    always_ff @(posedge clk) begin
        if (read_en) begin
            rd_data <= tap_data;
        end
    end

    // ------------------------------------------------------------------
    // reject pulses
    // ------------------------------------------------------------------
    // one cycle per rejected strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_reject <= 1'b0;
            rd_reject <= 1'b0;
        end else begin
            wr_reject <= wr_en & ~write_en;
            rd_reject <= rd_en & ~read_en;
        end
    end

endmodule

// ==== fifo_watermark_regs.sv ====
// ------------------------------------------------------------------
// FIFO watermark and status register block
// thresholds, almost flags, sticky errors and register read-back
// ------------------------------------------------------------------

`timescale 1ns/1ns

`include "srl_fifo_consts.svh"

module fifo_watermark_regs (
    input  logic                    clk,
    input  logic                    reset,

    input  srl_fifo_pkg::count_t    data_count,
    input  logic                    empty,
    input  logic                    full,
    input  logic                    wr_reject,
    input  logic                    rd_reject,

    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  srl_fifo_pkg::reg_addr_t reg_addr,
    input  srl_fifo_pkg::reg_data_t reg_wdata,
    output srl_fifo_pkg::reg_data_t reg_rdata,

    output logic                    almost_full,
    output logic                    almost_empty
);

    // programmable thresholds
    srl_fifo_pkg::reg_data_t af_thresh;
    srl_fifo_pkg::reg_data_t ae_thresh;

    // sticky error flags
    logic                    overflow;
    logic                    underflow;

    // count widened to register width
    srl_fifo_pkg::reg_data_t count_word;
    srl_fifo_pkg::reg_data_t status_word;
    srl_fifo_pkg::reg_data_t rdata_mux;
    logic                    status_wr;

    assign count_word = srl_fifo_pkg::reg_data_t'(data_count);
    assign status_wr  = reg_wr && (reg_addr == `REG_ADDR_STATUS);

    // ------------------------------------------------------------------
    // threshold registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            af_thresh <= `AF_THRESH_RESET;
            ae_thresh <= `AE_THRESH_RESET;
        end else if (reg_wr) begin
            if (reg_addr == `REG_ADDR_AF_THRESH) begin
                af_thresh <= reg_wdata;
            end
            if (reg_addr == `REG_ADDR_AE_THRESH) begin
                ae_thresh <= reg_wdata;
            end
        end
    end

    // ------------------------------------------------------------------
    // almost flags
    // ------------------------------------------------------------------
    // registered, one cycle behind the count
    always_ff @(posedge clk) begin
        if (reset) begin
            almost_full  <= 1'b0;
            almost_empty <= 1'b1;
        end else begin
            almost_full  <= (count_word >= af_thresh);
            almost_empty <= (count_word <= ae_thresh);
        end
    end

    // ------------------------------------------------------------------
    // sticky error flags
    // ------------------------------------------------------------------
    // write-one-to-clear, a new reject in the same cycle wins
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (wr_reject) begin
                overflow <= 1'b1;
            end else if (status_wr && reg_wdata[4]) begin
                overflow <= 1'b0;
            end

            if (rd_reject) begin
                underflow <= 1'b1;
            end else if (status_wr && reg_wdata[5]) begin
                underflow <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // read-back
    // ------------------------------------------------------------------
    assign status_word = {2'b00, underflow, overflow,
                          almost_full, almost_empty, full, empty};

    always_comb begin
        case (reg_addr)
            `REG_ADDR_AF_THRESH: rdata_mux = af_thresh;
            `REG_ADDR_AE_THRESH: rdata_mux = ae_thresh;
            `REG_ADDR_STATUS:    rdata_mux = status_word;
            default:             rdata_mux = count_word;
        endcase
    end

    // held until the next read strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rdata_mux;
        end
    end

endmodule

// ==== srl_fifo_top.sv ====
// ------------------------------------------------------------------
// byte FIFO subsystem top level
// FIFO core plus its watermark and status register block
// ------------------------------------------------------------------

`timescale 1ns/1ns

module srl_fifo_top (
    input  logic                    clk,
    input  logic                    reset,

    // write side
    input  logic                    wr_en,
    input  srl_fifo_pkg::data_t     wr_data,

    // read side
    input  logic                    rd_en,
    output srl_fifo_pkg::data_t     rd_data,

    // levels
    output logic                    full,
    output logic                    empty,
    output logic                    almost_full,
    output logic                    almost_empty,

    // register port
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  srl_fifo_pkg::reg_addr_t reg_addr,
    input  srl_fifo_pkg::reg_data_t reg_wdata,
    output srl_fifo_pkg::reg_data_t reg_rdata
);

    // FIFO to register block
    srl_fifo_pkg::count_t data_count;
    logic                 wr_reject;
    logic                 rd_reject;

    // ------------------------------------------------------------------
    // FIFO core
    // ------------------------------------------------------------------
    srl_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .full       (full),
        .empty      (empty),
        .data_count (data_count),
        .free_count (),
        .wr_reject  (wr_reject),
        .rd_reject  (rd_reject)
    );

    // ------------------------------------------------------------------
    // register block
    // ------------------------------------------------------------------
    fifo_watermark_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .data_count   (data_count),
        .empty        (empty),
        .full         (full),
        .wr_reject    (wr_reject),
        .rd_reject    (rd_reject),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

endmodule

// ==== tb_srl_fifo.sv ====
// ----------------------------------------------------------------------
// directed testbench for the byte FIFO subsystem
// queue model of the FIFO and its registers, one task per test
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "srl_fifo_consts.svh"

module tb_srl_fifo;

    logic                    clk;
    logic                    reset;
    logic                    wr_en;
    srl_fifo_pkg::data_t     wr_data;
    logic                    rd_en;
    srl_fifo_pkg::data_t     rd_data;
    logic                    full;
    logic                    empty;
    logic                    almost_full;
    logic                    almost_empty;
    logic                    reg_wr;
    logic                    reg_rd;
    srl_fifo_pkg::reg_addr_t reg_addr;
    srl_fifo_pkg::reg_data_t reg_wdata;
    srl_fifo_pkg::reg_data_t reg_rdata;

    // reference model
    srl_fifo_pkg::data_t     model_q [$];
    srl_fifo_pkg::reg_data_t af_thresh_m;
    srl_fifo_pkg::reg_data_t ae_thresh_m;
    logic                    overflow_m;
    logic                    underflow_m;

    int                      seed = 32'h1a89b383;
    int                      value_errors = 0;
    int                      timeout_errors = 0;

    srl_fifo_top dut (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_data(input string name, input srl_fifo_pkg::data_t actual,
                              input srl_fifo_pkg::data_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input srl_fifo_pkg::reg_data_t actual,
                             input srl_fifo_pkg::reg_data_t expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            value_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // model helpers
    // ----------------------------------------------------------------------
    function automatic srl_fifo_pkg::data_t random_word();
        return srl_fifo_pkg::data_t'($random(seed));
    endfunction

    function automatic srl_fifo_pkg::reg_data_t expected_status();
        int n;
        n = model_q.size();
        return {2'b00, underflow_m, overflow_m, n >= af_thresh_m, n <= ae_thresh_m,
                n == `FIFO_DEPTH, n == 0};
    endfunction

    task automatic check_almost();
        int n;
        n = model_q.size();
        check_flag("almost_full", almost_full, n >= af_thresh_m);
        check_flag("almost_empty", almost_empty, n <= ae_thresh_m);
    endtask

    // ----------------------------------------------------------------------
    // stimulus, every task starts and ends on a falling edge
    // ----------------------------------------------------------------------
    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic wait_level(input string name, input logic value, input int limit);
        int   cycles;
        logic level;
        cycles = 0;
        level = (name == "full") ? full : empty;
        while (level !== value && cycles < limit) begin
            @(negedge clk);
            cycles++;
            level = (name == "full") ? full : empty;
        end
        if (level !== value) begin
            $display("timeout: %s did not reach %b within %0d cycles", name, value, limit);
            timeout_errors++;
        end
    endtask

    // one clock of the write and read strobes, checked against the model
    task automatic fifo_cycle(input logic wr, input srl_fifo_pkg::data_t wdata, input logic rd);
        int                  n;
        logic                wr_ok;
        logic                rd_ok;
        srl_fifo_pkg::data_t exp_word;
        n = model_q.size();
        rd_ok = rd && (n > 0);
        // a read in the same cycle makes room for the write when full
        wr_ok = wr && ((n < `FIFO_DEPTH) || rd_ok);
        exp_word = '0;
        if (rd_ok) exp_word = model_q.pop_front();
        if (wr_ok) model_q.push_back(wdata);
        if (wr && !wr_ok) overflow_m = 1'b1;
        if (rd && !rd_ok) underflow_m = 1'b1;
        wr_en = wr;
        wr_data = wdata;
        rd_en = rd;
        @(negedge clk);
        wr_en = 1'b0;
        wr_data = '0;
        rd_en = 1'b0;
        if (rd_ok) check_data("rd_data", rd_data, exp_word);
        check_flag("empty", empty, model_q.size() == 0);
        check_flag("full", full, model_q.size() == `FIFO_DEPTH);
    endtask

    task automatic fill(input int words);
        repeat (words) fifo_cycle(1'b1, random_word(), 1'b0);
    endtask

    task automatic drain();
        while (model_q.size() > 0) fifo_cycle(1'b0, '0, 1'b1);
    endtask

    task automatic write_reg(input srl_fifo_pkg::reg_addr_t addr,
                             input srl_fifo_pkg::reg_data_t data);
        case (addr)
            `REG_ADDR_AF_THRESH: af_thresh_m = data;
            `REG_ADDR_AE_THRESH: ae_thresh_m = data;
            `REG_ADDR_STATUS: begin
                if (data[4]) overflow_m = 1'b0;
                if (data[5]) underflow_m = 1'b0;
            end
            default: ;
        endcase
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
        reg_wdata = '0;
    endtask

    // one idle clock first so sticky and almost flags have settled
    task automatic read_reg(input string name, input srl_fifo_pkg::reg_addr_t addr,
                            input srl_fifo_pkg::reg_data_t expected);
        idle(1);
        reg_rd = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        check_reg(name, reg_rdata, expected);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        check_flag("empty", empty, 1'b1);
        check_flag("full", full, 1'b0);
        check_almost();
        read_reg("status", `REG_ADDR_STATUS, expected_status());
        read_reg("count", `REG_ADDR_COUNT, 8'h00);
    endtask

    task automatic test_fill_drain();
        fill(`FIFO_DEPTH);
        wait_level("full", 1'b1, 2);
        read_reg("count", `REG_ADDR_COUNT, srl_fifo_pkg::reg_data_t'(model_q.size()));
        drain();
        wait_level("empty", 1'b1, 2);
    endtask

    task automatic test_simultaneous();
        fill(`FIFO_DEPTH);
        // read and write together while full
        fifo_cycle(1'b1, random_word(), 1'b1);
        read_reg("count", `REG_ADDR_COUNT, srl_fifo_pkg::reg_data_t'(model_q.size()));
        read_reg("status", `REG_ADDR_STATUS, expected_status());
        drain();
        write_reg(`REG_ADDR_STATUS, 8'h30);
        // only the write counts while empty
        fifo_cycle(1'b1, random_word(), 1'b1);
        read_reg("count", `REG_ADDR_COUNT, srl_fifo_pkg::reg_data_t'(model_q.size()));
        read_reg("status", `REG_ADDR_STATUS, expected_status());
        drain();
        write_reg(`REG_ADDR_STATUS, 8'h30);
    endtask

    task automatic test_sticky_errors();
        fifo_cycle(1'b0, '0, 1'b1);
        fill(`FIFO_DEPTH);
        fifo_cycle(1'b1, random_word(), 1'b0);
        read_reg("status", `REG_ADDR_STATUS, expected_status());
        write_reg(`REG_ADDR_STATUS, 8'h30);
        read_reg("status", `REG_ADDR_STATUS, expected_status());
        read_reg("count", `REG_ADDR_COUNT, srl_fifo_pkg::reg_data_t'(model_q.size()));
        // rejected word must not show up here
        drain();
    endtask

    task automatic test_watermarks();
        write_reg(`REG_ADDR_AF_THRESH, 8'd10);
        write_reg(`REG_ADDR_AE_THRESH, 8'd5);
        read_reg("af_thresh", `REG_ADDR_AF_THRESH, af_thresh_m);
        read_reg("ae_thresh", `REG_ADDR_AE_THRESH, ae_thresh_m);
        repeat (`FIFO_DEPTH) begin
            fifo_cycle(1'b1, random_word(), 1'b0);
            idle(1);
            check_almost();
        end
        repeat (`FIFO_DEPTH) begin
            fifo_cycle(1'b0, '0, 1'b1);
            idle(1);
            check_almost();
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        wr_data = '0;
        rd_en = 1'b0;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        af_thresh_m = `AF_THRESH_RESET;
        ae_thresh_m = `AE_THRESH_RESET;
        overflow_m = 1'b0;
        underflow_m = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_level("empty", 1'b1, 4);

        test_reset();
        test_fill_drain();
        test_simultaneous();
        test_sticky_errors();
        test_watermarks();

        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
srl_fifo_pkg.sv
srl_shift_register.sv
srl_fifo.sv
fifo_watermark_regs.sv
srl_fifo_top.sv
tb_srl_fifo.sv
